// File: Makefile
TOP = data_feeder_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f data_feeder.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f data_feeder.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/dram_pkg.sv
package dram_pkg;

    // ########################################################################
    // line geometry
    // ########################################################################
    localparam int LINE_BYTES     = 64;
    localparam int WORD_BITS      = 16;
    localparam int WORDS_PER_LINE = 32;
    localparam int LINE_BITS      = LINE_BYTES * 8;
    localparam int LINE_OFS_BITS  = $clog2(LINE_BYTES);   // byte offset inside a line
    localparam int WORD_BYTES     = WORD_BITS / 8;

    // one dram line, word k sits at bits 16k+15 .. 16k
    typedef logic [LINE_BITS-1:0] line_t;

    typedef logic [WORD_BITS-1:0] word_t;

    typedef logic [31:0] dram_addr_t;

    // request direction
    localparam logic REQ_READ  = 1'b0;
    localparam logic REQ_WRITE = 1'b1;

    // ########################################################################
    // request fifo entry
    // ########################################################################
    typedef struct packed {
        dram_addr_t addr;   // byte address, need not be line aligned
        logic       rw;     // 0 read
    } dram_req_t;

endpackage

// File: common/feeder_pkg.sv
package feeder_pkg;

    import dram_pkg::*;

    // ########################################################################
    // register map, offsets on the processor bus
    // ########################################################################
    localparam dram_addr_t REG_RD_ADDR   = 32'h0000_0000;  // start byte address
    localparam dram_addr_t REG_RD_LEN    = 32'h0000_0004;  // words per round
    localparam dram_addr_t REG_RD_ROUNDS = 32'h0000_0008;  // round count
    localparam dram_addr_t REG_RD_STRIDE = 32'h0000_000C;  // bytes between rounds
    localparam dram_addr_t REG_DATA_TYPE = 32'h0000_0010;  // 0 input, 1 weight
    localparam dram_addr_t REG_INDEX_CLR = 32'h0000_0014;  // any write clears index
    localparam dram_addr_t REG_START     = 32'h0000_0018;  // bit 0 picks destination
    localparam dram_addr_t REG_BUSY      = 32'h0000_001C;  // read only
    localparam dram_addr_t REG_SW_DATA   = 32'h0000_0020;  // read only

    // accelerator command codes
    localparam logic [7:0] CMD_WRITE_INPUT  = 8'd9;
    localparam logic [7:0] CMD_WRITE_WEIGHT = 8'd10;

    // ########################################################################
    // transfer configuration, held by the register block
    // ########################################################################
    typedef struct packed {
        dram_addr_t  rd_addr;
        logic [14:0] rd_len;
        logic [15:0] rd_rounds;
        logic [31:0] rd_stride;
        logic        data_type;
        logic        to_accel;    // 0 means software read-back
    } feed_cfg_t;

    // one word for the accelerator
    typedef struct packed {
        logic [7:0]  cmd;
        word_t       param_data;
        logic [14:0] param_index;
    } accel_cmd_t;

endpackage

// File: data_feeder.f
common/dram_pkg.sv
common/feeder_pkg.sv
verilog/csr_block.sv
dram_read/read_requester.sv
dram_read/line_unpacker.sv
verilog/data_feeder.sv
verification/data_feeder_props.sv
verification/data_feeder_tb.sv

// File: dram_read/line_unpacker.sv
`timescale 1ns/1ps

module line_unpacker import dram_pkg::*, feeder_pkg::*; #(
    parameter int ADDR_BITS = 15
) (
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       start_i,
    input  feed_cfg_t  cfg_i,
    input  logic       index_clr_i,

    input  line_t      dram_rdata_i,
    input  logic       dram_rdata_empty_i,
    output logic       dram_rdata_pop_o,

    output logic       cmd_req_o,
    input  logic       cmd_ack_i,
    output accel_cmd_t cmd_o,

    output word_t      sw_data_o,
    output logic       busy_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_LINE,
        SEND_WORD,      // req high until ack
        WAIT_ACK_LOW,
        POP,
        NEXT_ROUND
    } unp_state_t;

    unp_state_t           state;
    unp_state_t           state_nx;
    dram_addr_t           word_addr;    // byte address of the next word
    dram_addr_t           round_base;
    logic [ADDR_BITS-1:0] sent_cnt;     // words sent this round
    logic [ADDR_BITS-1:0] index;        // running buffer index
    logic [15:0]          round_cnt;
    word_t                head_word;
    logic                 round_done;
    logic                 line_done;
    logic                 last_round;
    accel_cmd_t           cmd_r;
    word_t                sw_data_r;

    // word picked out of the fifo head line
    assign head_word = dram_rdata_i[word_addr[LINE_OFS_BITS-1:1] * WORD_BITS +: WORD_BITS];

    assign round_done = (sent_cnt >= cfg_i.rd_len);
    assign line_done  = (word_addr[LINE_OFS_BITS-1:0] == '0);   // stepped into next line
    assign last_round = (round_cnt + 16'd1 >= cfg_i.rd_rounds);

    // ########################################################################
    // fsm
    // ########################################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: if (start_i) state_nx = WAIT_LINE;
            WAIT_LINE: begin
                if (!dram_rdata_empty_i) begin
                    state_nx = cfg_i.to_accel ? SEND_WORD : POP;
                end
            end
            SEND_WORD: if (cmd_ack_i) state_nx = WAIT_ACK_LOW;
            WAIT_ACK_LOW: begin
                if (!cmd_ack_i) begin
                    state_nx = (round_done || line_done) ? POP : SEND_WORD;
                end
            end
            POP: begin
                if (!cfg_i.to_accel) begin
                    state_nx = IDLE;
                end else begin
                    state_nx = round_done ? NEXT_ROUND : WAIT_LINE;
                end
            end
            NEXT_ROUND: state_nx = last_round ? IDLE : WAIT_LINE;
            default:    state_nx = IDLE;
        endcase
    end

    // word address and counters
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            word_addr  <= '0;
            round_base <= '0;
            sent_cnt   <= '0;
            round_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        word_addr  <= cfg_i.rd_addr;
                        round_base <= cfg_i.rd_addr;
                        sent_cnt   <= '0;
                        round_cnt  <= '0;
                    end
                end
                SEND_WORD: begin
                    if (cmd_ack_i) begin
                        word_addr <= word_addr + dram_addr_t'(WORD_BYTES);
                        sent_cnt  <= sent_cnt + 1'b1;
                    end
                end
                NEXT_ROUND: begin
                    word_addr  <= round_base + cfg_i.rd_stride;
                    round_base <= round_base + cfg_i.rd_stride;
                    sent_cnt   <= '0;
                    round_cnt  <= round_cnt + 16'd1;
                end
                default: ;
            endcase
        end
    end

    // index survives across transfers, only a clear resets it
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            index <= '0;
        end else if (index_clr_i) begin
            index <= '0;
        end else if (state == SEND_WORD && cmd_ack_i) begin
            index <= index + 1'b1;
        end
    end

    // ########################################################################
    // command and read-back capture
    // ########################################################################
    always_ff @(posedge clk_i) begin
        if (state_nx == SEND_WORD && state != SEND_WORD) begin
            cmd_r.cmd         <= cfg_i.data_type ? CMD_WRITE_WEIGHT : CMD_WRITE_INPUT;
            cmd_r.param_data  <= head_word;
            cmd_r.param_index <= index;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == WAIT_LINE && !dram_rdata_empty_i && !cfg_i.to_accel) begin
            sw_data_r <= head_word;     // word at rd_addr
        end
    end

    assign cmd_req_o        = (state == SEND_WORD);
    assign cmd_o            = cmd_r;
    assign dram_rdata_pop_o = (state == POP);
    assign sw_data_o        = sw_data_r;
    assign busy_o           = (state != IDLE);

endmodule

// File: dram_read/read_requester.sv
`timescale 1ns/1ps

module read_requester import dram_pkg::*, feeder_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,

    input  logic      start_i,
    input  feed_cfg_t cfg_i,

    input  logic      dram_req_full_i,
    output logic      dram_req_valid_o,
    output dram_req_t dram_req_o,

    output logic      busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ROOM,     // one cycle at least, checks the request fifo
        SEND,
        NEXT_ROUND
    } req_state_t;

    req_state_t               state;
    req_state_t               state_nx;
    dram_addr_t               cur_addr;
    dram_addr_t               round_base;
    logic [15:0]              req_cnt;      // words covered this round
    logic [15:0]              round_cnt;
    logic [LINE_OFS_BITS:0]   line_bytes;
    logic [LINE_OFS_BITS-1:0] line_words;
    logic                     last_req;
    logic                     last_round;

    // bytes left up to the end of the current line
    assign line_bytes = (LINE_OFS_BITS + 1)'(LINE_BYTES) - {1'b0, cur_addr[LINE_OFS_BITS-1:0]};
    assign line_words = line_bytes[LINE_OFS_BITS:1];

    // software read-back only ever needs one line
    assign last_req   = (req_cnt + 16'(line_words) >= {1'b0, cfg_i.rd_len}) || !cfg_i.to_accel;
    assign last_round = (round_cnt + 16'd1 >= cfg_i.rd_rounds) || !cfg_i.to_accel;

    // ########################################################################
    // fsm
    // ########################################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:       if (start_i) state_nx = WAIT_ROOM;
            WAIT_ROOM:  if (!dram_req_full_i) state_nx = SEND;
            SEND:       state_nx = last_req ? NEXT_ROUND : WAIT_ROOM;
            NEXT_ROUND: state_nx = last_round ? IDLE : WAIT_ROOM;
            default:    state_nx = IDLE;
        endcase
    end

    // address and counters
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cur_addr   <= '0;
            round_base <= '0;
            req_cnt    <= '0;
            round_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        cur_addr   <= cfg_i.rd_addr;
                        round_base <= cfg_i.rd_addr;
                        req_cnt    <= '0;
                        round_cnt  <= '0;
                    end
                end
                SEND: begin
                    cur_addr <= cur_addr + dram_addr_t'(line_bytes);   // next line start
                    req_cnt  <= req_cnt + 16'(line_words);
                end
                NEXT_ROUND: begin
                    cur_addr   <= round_base + cfg_i.rd_stride;
                    round_base <= round_base + cfg_i.rd_stride;
                    req_cnt    <= '0;
                    round_cnt  <= round_cnt + 16'd1;
                end
                default: ;
            endcase
        end
    end

    assign dram_req_valid_o = (state == SEND);
    assign dram_req_o       = '{addr: cur_addr, rw: REQ_READ};
    assign busy_o           = (state != IDLE);

endmodule

// File: verification/data_feeder_props.sv
`timescale 1ns/1ps

module data_feeder_props import dram_pkg::*, feeder_pkg::*; (
    input logic       clk_i,
    input logic       rst_i,
    input logic       cmd_req_i,
    input logic       cmd_ack_i,
    input accel_cmd_t cmd_i,
    input logic       req_full_i,
    input logic       req_valid_i,
    input logic       rdata_empty_i,
    input logic       rdata_pop_i
);

    int fail_count = 0;     // read by the testbench at the end

    // a new request waits until the old ack is gone
    assert property (@(posedge clk_i) disable iff (rst_i)
                     $rose(cmd_req_i) |-> !$past(cmd_ack_i))
        else begin
            fail_count++;
            $error("cmd_req raised while cmd_ack still high");
        end

    assert property (@(posedge clk_i) disable iff (rst_i)
                     cmd_req_i && $past(cmd_req_i) |-> $stable(cmd_i))
        else begin
            fail_count++;
            $error("cmd changed while cmd_req high");
        end

    // request only after full was seen low
    assert property (@(posedge clk_i) disable iff (rst_i) $past(req_full_i) |-> !req_valid_i)
        else begin
            fail_count++;
            $error("dram request issued after full flag");
        end

    assert property (@(posedge clk_i) disable iff (rst_i) rdata_pop_i |-> !rdata_empty_i)
        else begin
            fail_count++;
            $error("read-data fifo popped while empty");
        end

endmodule

bind data_feeder data_feeder_props u_props (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_req_i     (cmd_req_o),
    .cmd_ack_i     (cmd_ack_i),
    .cmd_i         (cmd_o),
    .req_full_i    (dram_req_full_i),
    .req_valid_i   (dram_req_valid_o),
    .rdata_empty_i (dram_rdata_empty_i),
    .rdata_pop_i   (dram_rdata_pop_o)
);

// File: verification/data_feeder_tb.sv
`timescale 1ns/1ps

module data_feeder_tb
    import dram_pkg::*, feeder_pkg::*;
();

    logic        clk_i;
    logic        rst_i;
    logic        bus_strobe_i;
    logic        bus_we_i;
    dram_addr_t  bus_addr_i;
    logic [31:0] bus_wdata_i;
    logic        bus_ready_o;
    logic [31:0] bus_rdata_o;
    logic        dram_req_full_i = 1'b0;
    logic        dram_req_valid_o;
    dram_req_t   dram_req_o;
    line_t       dram_rdata_i = '0;
    logic        dram_rdata_empty_i = 1'b1;
    logic        dram_rdata_pop_o;
    logic        cmd_req_o;
    logic        cmd_ack_i = 1'b0;
    accel_cmd_t  cmd_o;

    // dram and accelerator model state
    logic [31:0] lfsr = 32'hcbf2;
    dram_addr_t  line_q[$];        // line addresses waiting in the read fifo
    int          arrive_q[$];      // cycle from which each line is visible
    dram_addr_t  exp_req_q[$];
    accel_cmd_t  exp_cmd_q[$];
    logic        pop_seen = 1'b0;
    logic        req_seen = 1'b0;
    dram_addr_t  req_seen_addr = '0;
    int          cycle = 0;
    int          arr;
    int          ack_wait = 0;
    int          pops = 0;
    int          cmds = 0;
    logic        rand_full = 1'b0;
    logic        rand_ack = 1'b0;
    logic        slow = 1'b0;      // late lines and late acks
    logic [14:0] exp_index = '0;
    int          value_errors = 0;
    int          other_errors = 0;
    string       test_name = "";
    logic [31:0] rd;
    int          pops_before;
    int          cmds_before;

    data_feeder #(.ADDR_BITS(15)) dut (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    // ########################################################################
    // helpers
    // ########################################################################
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // x^32+x^22+x^2+x+1
            lfsr = {lfsr[30:0], fb};
            r    = {r[6:0], fb};
        end
        return r;
    endfunction

    // memory content: word k of a line is (line address + 2k) xor a5a5
    function automatic word_t mem_word(input dram_addr_t line_addr, input int k);
        dram_addr_t a;
        a = line_addr + dram_addr_t'(2 * k);
        return a[15:0] ^ 16'ha5a5;
    endfunction

    function automatic word_t word_at(input dram_addr_t addr);
        return mem_word({addr[31:6], 6'd0}, int'(addr[5:1]));
    endfunction

    function automatic line_t make_line(input dram_addr_t addr);
        line_t l;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            l[k * WORD_BITS +: WORD_BITS] = mem_word({addr[31:6], 6'd0}, k);
        end
        return l;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp == act) else begin
            value_errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic finish_run();
        int total;
        total = value_errors + other_errors + dut.u_props.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 dut.u_props.fail_count);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        other_errors++;
        $display("ERROR: %s timed out in test %s", what, test_name);
        finish_run();
    endtask

    // ########################################################################
    // processor bus
    // ########################################################################
    task automatic bus_access(input logic we, input dram_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        @(posedge clk_i);
        #1;
        bus_strobe_i = 1'b1;
        bus_we_i     = we;
        bus_addr_i   = addr;
        bus_wdata_i  = wdata;
        @(posedge clk_i);
        #1;
        bus_strobe_i = 1'b0;
        n = 0;
        while (!bus_ready_o && n < 16) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (!bus_ready_o) begin
            give_up("bus ready");
        end else begin
            rdata = bus_rdata_o;
        end
    endtask

    task automatic bus_write(input dram_addr_t addr, input logic [31:0] data);
        logic [31:0] rd_dummy;
        bus_access(1'b1, addr, data, rd_dummy);
    endtask

    task automatic bus_read(input dram_addr_t addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'd0, data);
    endtask

    task automatic wait_idle();
        logic [31:0] busy;
        int          n;
        busy = 32'd1;
        n = 0;
        while (busy[0] && n < 3000) begin
            bus_read(REG_BUSY, busy);
            n++;
        end
        if (busy[0]) give_up("transfer end");
    endtask

    // expected requests and commands, straight from the address rule
    task automatic plan_transfer(input dram_addr_t addr, input logic [31:0] len,
                                 input logic [31:0] rounds, input logic [31:0] stride,
                                 input logic weight);
        dram_addr_t base;
        dram_addr_t a;
        int         cnt;
        accel_cmd_t c;
        base = addr;
        for (int r = 0; r < int'(rounds); r++) begin
            a = base;
            cnt = 0;
            while (cnt < int'(len)) begin
                exp_req_q.push_back(a);
                cnt += (64 - int'(a[5:0])) / 2;
                a = {a[31:6], 6'd0} + 32'd64;      // next line start
            end
            a = base;
            for (int i = 0; i < int'(len); i++) begin
                c.cmd         = weight ? CMD_WRITE_WEIGHT : CMD_WRITE_INPUT;
                c.param_data  = word_at(a);
                c.param_index = exp_index;
                exp_cmd_q.push_back(c);
                exp_index++;
                a = a + 32'd2;
            end
            base = base + stride;
        end
    endtask

    task automatic run_transfer(input dram_addr_t addr, input logic [31:0] len,
                                input logic [31:0] rounds, input logic [31:0] stride,
                                input logic weight);
        logic [31:0] busy;
        bus_write(REG_RD_ADDR, addr);
        bus_write(REG_RD_LEN, len);
        bus_write(REG_RD_ROUNDS, rounds);
        bus_write(REG_RD_STRIDE, stride);
        bus_write(REG_DATA_TYPE, {31'd0, weight});
        plan_transfer(addr, len, rounds, stride, weight);
        bus_write(REG_START, 32'd1);
        bus_read(REG_BUSY, busy);
        check_value("busy while running", 64'd1, 64'(busy));
        wait_idle();
        check_value("commands missing", 64'd0, 64'(exp_cmd_q.size()));
        check_value("requests missing", 64'd0, 64'(exp_req_q.size()));
        check_value("lines left in fifo", 64'd0, 64'(line_q.size()));
    endtask

    // ########################################################################
    // dram fifos and accelerator
    // ########################################################################
    always begin
        @(posedge clk_i);
        #1;
        cycle++;
        // effects of the previous cycle's outputs
        if (pop_seen) begin
            if (line_q.size() > 0) begin
                void'(line_q.pop_front());
                void'(arrive_q.pop_front());
            end
            pops++;
        end
        if (req_seen) begin
            arr = cycle + (slow ? 4 + int'(take_bits(5)) : 2);
            if (arrive_q.size() > 0 && arrive_q[$] > arr) begin
                arr = arrive_q[$];  // fifo keeps order
            end
            line_q.push_back(req_seen_addr);
            arrive_q.push_back(arr);
        end
        dram_rdata_empty_i = !(line_q.size() > 0 && arrive_q[0] <= cycle);
        dram_rdata_i       = (line_q.size() > 0) ? make_line(line_q[0]) : '0;
        dram_req_full_i    = rand_full && (take_bits(2) == 8'd0);

        pop_seen      = dram_rdata_pop_o;
        req_seen      = dram_req_valid_o;
        req_seen_addr = dram_req_o.addr;
        if (dram_req_valid_o) begin
            if (exp_req_q.size() == 0) begin
                other_errors++;
                $display("ERROR: unexpected dram request in test %s", test_name);
            end else begin
                check_value("request", 64'({exp_req_q[0], REQ_READ}), 64'(dram_req_o));
                void'(exp_req_q.pop_front());
            end
        end

        if (cmd_ack_i) begin
            if (!cmd_req_o) cmd_ack_i = 1'b0;
        end else if (cmd_req_o) begin
            if (ack_wait > 0) begin
                ack_wait--;
            end else begin
                if (exp_cmd_q.size() == 0) begin
                    other_errors++;
                    $display("ERROR: extra accelerator command in test %s", test_name);
                end else begin
                    check_value("command", 64'(exp_cmd_q[0]), 64'(cmd_o));
                    void'(exp_cmd_q.pop_front());
                end
                cmds++;
                cmd_ack_i = 1'b1;
                ack_wait  = slow ? 12 : (rand_ack ? int'(take_bits(3)) : 0);
            end
        end
    end

    // ########################################################################
    // test sequence
    // ########################################################################
    initial begin
        rst_i        = 1'b1;
        bus_strobe_i = 1'b0;
        bus_we_i     = 1'b0;
        bus_addr_i   = '0;
        bus_wdata_i  = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        test_name = "reset";
        check_value("bus_ready_o", 64'd0, 64'(bus_ready_o));
        check_value("dram_req_valid_o", 64'd0, 64'(dram_req_valid_o));
        check_value("dram_rdata_pop_o", 64'd0, 64'(dram_rdata_pop_o));
        check_value("cmd_req_o", 64'd0, 64'(cmd_req_o));
        bus_read(REG_BUSY, rd);
        check_value("busy", 64'd0, 64'(rd));

        test_name = "unaligned input";
        bus_write(REG_INDEX_CLR, 32'd0);
        exp_index = '0;
        run_transfer(32'h1006, 32'd70, 32'd1, 32'd0, 1'b0);

        test_name = "strided weight";
        rand_full = 1'b1;
        rand_ack  = 1'b1;
        run_transfer(32'h2010, 32'd40, 32'd3, 32'h104, 1'b1);

        test_name = "back-pressure";
        rand_full = 1'b0;
        rand_ack  = 1'b0;
        slow      = 1'b1;
        // index is well above zero here, so the clear has to act
        bus_write(REG_INDEX_CLR, 32'd0);
        exp_index = '0;
        run_transfer(32'h047c, 32'd50, 32'd2, 32'h80, 1'b0);
        slow = 1'b0;

        test_name   = "software read-back";
        pops_before = pops;
        cmds_before = cmds;
        bus_write(REG_RD_ADDR, 32'h3022);
        exp_req_q.push_back(32'h3022);
        bus_write(REG_START, 32'd0);
        wait_idle();
        bus_read(REG_SW_DATA, rd);
        check_value("sw data", 64'(word_at(32'h3022)), 64'(rd));
        check_value("lines popped", 64'd1, 64'(pops - pops_before));
        check_value("commands sent", 64'd0, 64'(cmds - cmds_before));
        check_value("requests missing", 64'd0, 64'(exp_req_q.size()));

        finish_run();
    end

endmodule

// File: verilog/csr_block.sv
`timescale 1ns/1ps

module csr_block import dram_pkg::*, feeder_pkg::*; #(
    parameter int ADDR_BITS = 15
) (
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic        bus_strobe_i,
    input  logic        bus_we_i,
    input  dram_addr_t  bus_addr_i,
    input  logic [31:0] bus_wdata_i,

    input  logic        req_busy_i,
    input  logic        unp_busy_i,
    input  word_t       sw_data_i,

    output logic        bus_ready_o,
    output logic [31:0] bus_rdata_o,

    output feed_cfg_t   cfg_o,
    output logic        start_o,
    output logic        index_clr_o
);

    logic      wr_hit;
    logic      rd_hit;
    logic      busy;
    logic      start_r;
    logic      index_clr_r;
    feed_cfg_t cfg_r;

    assign wr_hit = bus_strobe_i && bus_we_i;
    assign rd_hit = bus_strobe_i && !bus_we_i;

    // start pulse counts as busy so a second start cannot slip in
    assign busy = req_busy_i || unp_busy_i || start_r;

    // ########################################################################
    // configuration registers
    // ########################################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_r.rd_addr   <= '0;
            cfg_r.rd_len    <= '0;
            cfg_r.rd_rounds <= 16'd1;
            cfg_r.rd_stride <= '0;
            cfg_r.data_type <= 1'b0;
            cfg_r.to_accel  <= 1'b0;
        end else if (wr_hit) begin
            case (bus_addr_i)
                REG_RD_ADDR:   cfg_r.rd_addr   <= bus_wdata_i;
                REG_RD_LEN:    cfg_r.rd_len    <= bus_wdata_i[ADDR_BITS-1:0];
                REG_RD_ROUNDS: cfg_r.rd_rounds <= bus_wdata_i[15:0];
                REG_RD_STRIDE: cfg_r.rd_stride <= bus_wdata_i;
                REG_DATA_TYPE: cfg_r.data_type <= bus_wdata_i[0];
                REG_START: begin
                    if (!busy) begin
                        cfg_r.to_accel <= bus_wdata_i[0];   // destination of this run
                    end
                end
                default: ;
            endcase
        end
    end

    // one cycle control pulses
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_r     <= 1'b0;
            index_clr_r <= 1'b0;
        end else begin
            start_r     <= wr_hit && (bus_addr_i == REG_START) && !busy;
            index_clr_r <= wr_hit && (bus_addr_i == REG_INDEX_CLR);
        end
    end

    // ########################################################################
    // bus response
    // ########################################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus_ready_o <= 1'b0;
        end else begin
            bus_ready_o <= bus_strobe_i;    // always one cycle after strobe
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_hit) begin
            case (bus_addr_i)
                REG_BUSY:    bus_rdata_o <= {31'd0, busy};
                REG_SW_DATA: bus_rdata_o <= {{(32 - WORD_BITS){1'b0}}, sw_data_i};
                default:     bus_rdata_o <= '0;
            endcase
        end
    end

    assign cfg_o       = cfg_r;
    assign start_o     = start_r;
    assign index_clr_o = index_clr_r;

endmodule

// File: verilog/data_feeder.sv
`timescale 1ns/1ps

module data_feeder import dram_pkg::*, feeder_pkg::*; #(
    parameter int ADDR_BITS = 15
) (
    input  logic        clk_i,
    input  logic        rst_i,

    // processor bus
    input  logic        bus_strobe_i,
    input  logic        bus_we_i,
    input  dram_addr_t  bus_addr_i,
    input  logic [31:0] bus_wdata_i,
    output logic        bus_ready_o,
    output logic [31:0] bus_rdata_o,

    // dram request fifo
    input  logic        dram_req_full_i,
    output logic        dram_req_valid_o,
    output dram_req_t   dram_req_o,

    // dram read-data fifo
    input  line_t       dram_rdata_i,
    input  logic        dram_rdata_empty_i,
    output logic        dram_rdata_pop_o,

    // accelerator commands
    output logic        cmd_req_o,
    input  logic        cmd_ack_i,
    output accel_cmd_t  cmd_o
);

    feed_cfg_t cfg;
    logic      start;
    logic      index_clr;
    logic      req_busy;
    logic      unp_busy;
    word_t     sw_data;

    csr_block #(
        .ADDR_BITS (ADDR_BITS)
    ) u_csr (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bus_strobe_i (bus_strobe_i),
        .bus_we_i     (bus_we_i),
        .bus_addr_i   (bus_addr_i),
        .bus_wdata_i  (bus_wdata_i),
        .req_busy_i   (req_busy),
        .unp_busy_i   (unp_busy),
        .sw_data_i    (sw_data),
        .bus_ready_o  (bus_ready_o),
        .bus_rdata_o  (bus_rdata_o),
        .cfg_o        (cfg),
        .start_o      (start),
        .index_clr_o  (index_clr)
    );

    // both dram_read blocks walk the same address rule in step
    read_requester u_requester (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .start_i          (start),
        .cfg_i            (cfg),
        .dram_req_full_i  (dram_req_full_i),
        .dram_req_valid_o (dram_req_valid_o),
        .dram_req_o       (dram_req_o),
        .busy_o           (req_busy)
    );

    line_unpacker #(
        .ADDR_BITS (ADDR_BITS)
    ) u_unpacker (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start),
        .cfg_i              (cfg),
        .index_clr_i        (index_clr),
        .dram_rdata_i       (dram_rdata_i),
        .dram_rdata_empty_i (dram_rdata_empty_i),
        .dram_rdata_pop_o   (dram_rdata_pop_o),
        .cmd_req_o          (cmd_req_o),
        .cmd_ack_i          (cmd_ack_i),
        .cmd_o              (cmd_o),
        .sw_data_o          (sw_data),
        .busy_o             (unp_busy)
    );

endmodule
